/* verilog.f */
common/rf_pkg.sv
design/rf_write.sv
lane/lane_channel.sv
design/rf_read_mux.sv
design/rf_toplevel.sv
tests/rf_toplevel_sva.sv
tests/rf_toplevel_tb.sv

/* build.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f verilog.f \
        --top-module rf_toplevel_tb -o rf_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/rf_sim; then
    echo "Simulation failed"
    exit 1
fi

exit 0

/* tests/rf_toplevel_tb.sv */
module rf_toplevel_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import rf_pkg::*;

    localparam int CLK_HALF     = 2;
    localparam int RESET_CYCLES = 5;
    // Longer than the longest repeat run of 27 blocks times 15 periods
    localparam int HOLD_CYCLES  = 500;
    // Three runs of up to 405 blocks, the hold and about a hundred accesses stay far below
    localparam int TIMEOUT_CYCLES = 20000;

    logic               fpga_clock;
    logic               rst;
    logic [NB_GPIO-1:0] gpio_in;
    logic [NB_GPIO-1:0] gpio_out;
    integer             seed = 75;
    int                 cycle_count = 0;

    rf_toplevel u_dut (
        .i_fpga_clock (fpga_clock),
        .i_rst        (rst),
        .i_gpio_data  (gpio_in),
        .o_gpio_data  (gpio_out)
    );

    initial begin
        fpga_clock = 1'b0;
        forever #CLK_HALF fpga_clock = ~fpga_clock;
    end

    always @(posedge fpga_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT never went idle", cycle_count);
            $display("TESTS FAILED");
            $fatal(1, "Run stopped by timeout");
        end
    end

    // Strobe high for hold cycles with read data taken 3 cycles after the rising edge
    task automatic send_command(input logic [NB_ADDR-1:0] addr, input logic [NB_I_DATA-1:0] data,
                                input int hold, output logic [NB_GPIO-1:0] rdata);
        @(posedge fpga_clock);
        gpio_in <= {1'b1, addr, data};
        repeat (hold) @(posedge fpga_clock);
        gpio_in <= {1'b0, addr, data};
        @(posedge fpga_clock);
        @(negedge fpga_clock);
        rdata = gpio_out;
    endtask

    task automatic gpio_write(input logic [NB_ADDR-1:0] addr, input logic [NB_I_DATA-1:0] data);
        logic [NB_GPIO-1:0] unused;
        send_command(addr, data, 2, unused);
    endtask

    task automatic gpio_read(input logic [NB_ADDR-1:0] addr, output logic [NB_GPIO-1:0] rdata);
        send_command(addr, '0, 2, rdata);
    endtask

    task automatic check_value(input string name, input logic [NB_GPIO-1:0] expected,
                               input logic [NB_GPIO-1:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s expected 0x%08h actual 0x%08h", name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "Check failed");
        end
    endtask

    task automatic check_nonzero(input string name, input logic [NB_GPIO-1:0] actual);
        assert (actual != '0) else begin
            $display("[FAIL] %s expected nonzero actual 0x%08h", name, actual);
            $display("TESTS FAILED");
            $fatal(1, "Check failed");
        end
    endtask

    function automatic int count_ones(input logic [NB_BLOCK-1:0] value);
        int ones;
        ones = 0;
        for (int i = 0; i < NB_BLOCK; i++) begin
            if (value[i]) begin
                ones++;
            end
        end
        return ones;
    endfunction

    // Poll status until no lane is busy
    task automatic wait_idle();
        logic [NB_GPIO-1:0] status;
        status = '1;
        while (status[N_LANES-1:0] != '0) begin
            gpio_read(ADDR_RD_STATUS, status);
        end
    endtask

    // Random breaker setup that returns the totals one run should leave per lane
    task automatic configure_run(input err_mode_e mode, output int blocks, output int bits);
        logic [NB_BLOCK-1:0] mask;
        int burst;
        int period;
        int repeats;
        mask = {$random(seed), $random(seed)};
        if (mask == '0) begin
            mask = 64'h1;
        end
        burst   = 1 + ($unsigned($random(seed)) % 20);
        period  = burst + ($unsigned($random(seed)) % 8);
        repeats = 1 + ($unsigned($random(seed)) % 15);
        gpio_write(ADDR_MASK_LO, mask[21:0]);
        gpio_write(ADDR_MASK_MID, mask[43:22]);
        gpio_write(ADDR_MASK_HI, {2'b00, mask[63:44]});
        gpio_write(ADDR_BURST, NB_I_DATA'(burst));
        gpio_write(ADDR_PERIOD, NB_I_DATA'(period));
        gpio_write(ADDR_MODE, {16'd0, mode, NB_REPEAT_CNT'(repeats)});
        blocks = burst * repeats;
        bits   = blocks * count_ones(mask);
    endtask

    initial begin
        logic [NB_GPIO-1:0] rdata;
        int exp_blocks;
        int exp_bits;
        rst     = 1'b1;
        gpio_in = '0;
        repeat (RESET_CYCLES) @(posedge fpga_clock);
        rst <= 1'b0;

        gpio_read(ADDR_RD_STATUS, rdata);
        check_value("reset_status", 0, rdata);
        for (int l = 0; l < N_LANES; l++) begin
            gpio_read(ADDR_RD_BLK_ERR + NB_ADDR'(l), rdata);
            check_value($sformatf("reset_blk_lane%0d", l), 0, rdata);
            gpio_read(ADDR_RD_BIT_ERR + NB_ADDR'(l), rdata);
            check_value($sformatf("reset_bit_lane%0d", l), 0, rdata);
        end

        // Enable readback
        gpio_write(ADDR_LANE_ENABLE, 22'h5);
        gpio_read(ADDR_RD_STATUS, rdata);
        check_value("enable_status_5", 32'h50, rdata);
        gpio_write(ADDR_LANE_ENABLE, 22'hf);
        gpio_read(ADDR_RD_STATUS, rdata);
        check_value("enable_status_f", 32'hf0, rdata);

        // Repeat run on all lanes with block counters read first
        configure_run(ERR_REPEAT, exp_blocks, exp_bits);
        gpio_write(ADDR_UPDATE, 22'hf);
        wait_idle();
        for (int l = 0; l < N_LANES; l++) begin
            gpio_read(ADDR_RD_BLK_ERR + NB_ADDR'(l), rdata);
            check_value($sformatf("repeat_blk_lane%0d", l), exp_blocks, rdata);
            gpio_read(ADDR_RD_BLK_ERR + NB_ADDR'(l), rdata);
            check_value($sformatf("cleared_blk_lane%0d", l), 0, rdata);
            gpio_read(ADDR_RD_BIT_ERR + NB_ADDR'(l), rdata);
            check_value($sformatf("cleared_bit_lane%0d", l), 0, rdata);
        end

        // Second run with bit counters read first
        configure_run(ERR_REPEAT, exp_blocks, exp_bits);
        gpio_write(ADDR_UPDATE, 22'hf);
        wait_idle();
        for (int l = 0; l < N_LANES; l++) begin
            gpio_read(ADDR_RD_BIT_ERR + NB_ADDR'(l), rdata);
            check_value($sformatf("repeat_bit_lane%0d", l), exp_bits, rdata);
            gpio_read(ADDR_RD_BIT_ERR + NB_ADDR'(l), rdata);
            check_value($sformatf("cleared_bit_lane%0d", l), 0, rdata);
            gpio_read(ADDR_RD_BLK_ERR + NB_ADDR'(l), rdata);
            check_value($sformatf("cleared_blk_lane%0d", l), 0, rdata);
        end

        // Continuous errors on lane 1 only
        configure_run(ERR_CONT, exp_blocks, exp_bits);
        gpio_write(ADDR_UPDATE, 22'h2);
        gpio_read(ADDR_RD_STATUS, rdata);
        check_value("cont_status", 32'hf2, rdata);
        for (int l = 0; l < N_LANES; l++) begin
            if (l != 1) begin
                gpio_read(ADDR_RD_BLK_ERR + NB_ADDR'(l), rdata);
                check_value($sformatf("isolated_blk_lane%0d", l), 0, rdata);
                gpio_read(ADDR_RD_BIT_ERR + NB_ADDR'(l), rdata);
                check_value($sformatf("isolated_bit_lane%0d", l), 0, rdata);
            end
        end
        gpio_read(ADDR_RD_BLK_ERR + 9'd1, rdata);
        check_nonzero("cont_blk_first", rdata);
        // At least two full periods
        repeat (64) @(posedge fpga_clock);
        gpio_read(ADDR_RD_BLK_ERR + 9'd1, rdata);
        check_nonzero("cont_blk_second", rdata);
        gpio_read(ADDR_RD_STATUS, rdata);
        check_value("cont_still_busy", 32'hf2, rdata);

        // Lane 1 frozen while disabled in the middle of its run
        gpio_write(ADDR_LANE_ENABLE, 22'hd);
        gpio_read(ADDR_RD_STATUS, rdata);
        check_value("disabled_status", 32'hd2, rdata);
        gpio_read(ADDR_RD_BLK_ERR + 9'd1, rdata);
        repeat (64) @(posedge fpga_clock);
        gpio_read(ADDR_RD_BLK_ERR + 9'd1, rdata);
        check_value("disabled_blk_lane1", 0, rdata);
        gpio_write(ADDR_LANE_ENABLE, 22'hf);

        gpio_write(ADDR_MODE, {16'd0, ERR_OFF, 4'd0});
        gpio_write(ADDR_UPDATE, 22'h2);
        gpio_read(ADDR_RD_STATUS, rdata);
        check_value("off_status", 32'hf0, rdata);

        // Held strobe must start a single run on lane 0
        configure_run(ERR_REPEAT, exp_blocks, exp_bits);
        send_command(ADDR_UPDATE, 22'h1, HOLD_CYCLES, rdata);
        wait_idle();
        gpio_read(ADDR_RD_BLK_ERR, rdata);
        check_value("held_strobe_blk_lane0", exp_blocks, rdata);

        gpio_read(9'h1ff, rdata);
        check_value("unmapped_read", 0, rdata);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* tests/rf_toplevel_sva.sv */
module rf_toplevel_sva (
    input logic                                      i_fpga_clock,
    input logic                                      i_rst,
    input logic [rf_pkg::NB_GPIO-1:0]                i_gpio_data,
    input rf_pkg::rf_cmd_t                           i_cmd,
    input logic [rf_pkg::N_LANES-1:0]                i_enable,
    input logic [rf_pkg::N_LANES-1:0]                i_update,
    input logic [rf_pkg::N_LANES-1:0]                i_clear,
    input rf_pkg::lane_status_t [rf_pkg::N_LANES-1:0] i_status
);
    timeunit 1ns;
    timeprecision 100ps;

    import rf_pkg::*;

    logic rd_strobe;

    assign rd_strobe = i_cmd.strobe && (i_cmd.addr >= ADDR_RD_BLK_ERR);

    // Reset leaves read data and control vectors at zero
    a_reset_quiet: assert property (@(posedge i_fpga_clock)
        i_rst |=> (i_gpio_data == '0 && i_clear == '0 && i_enable == '0 && i_update == '0))
        else $error("Outputs not zero after reset");

    // Clear pulse one cycle after a read-space strobe
    a_clear_after_read: assert property (@(posedge i_fpga_clock) disable iff (i_rst)
        (i_clear != '0) |-> $past(rd_strobe))
        else $error("Clear pulse without a read-space command one cycle earlier");

    // Read data only moves one cycle after a read
    a_read_latency: assert property (@(posedge i_fpga_clock) disable iff (i_rst)
        $changed(i_gpio_data) |-> $past(rd_strobe))
        else $error("Read data changed without a read one cycle earlier");

    for (genvar l = 0; l < N_LANES; l++) begin : gen_lane_check
        a_lane_reset: assert property (@(posedge i_fpga_clock)
            i_rst |=> (i_status[l] == '0))
            else $error("Lane %0d status not zero after reset", l);

        a_hold_disabled: assert property (@(posedge i_fpga_clock) disable iff (i_rst)
            (!i_enable[l] && !i_clear[l]) |=>
                $stable({i_status[l].blk_err_cnt, i_status[l].bit_err_cnt}))
            else $error("Lane %0d counter changed while disabled", l);
    end

endmodule

bind rf_toplevel rf_toplevel_sva u_sva (
    .i_fpga_clock (i_fpga_clock),
    .i_rst        (i_rst),
    .i_gpio_data  (o_gpio_data),
    .i_cmd        (cmd),
    .i_enable     (lane_enable),
    .i_update     (lane_update),
    .i_clear      (lane_clear),
    .i_status     (lane_status)
);

/* design/rf_toplevel.sv */
module rf_toplevel (
    input  logic                       i_fpga_clock,
    input  logic                       i_rst,
    input  logic [rf_pkg::NB_GPIO-1:0] i_gpio_data,
    output logic [rf_pkg::NB_GPIO-1:0] o_gpio_data
);

    import rf_pkg::*;

    rf_cmd_t                    cmd;
    breaker_cfg_t               cfg;
    logic [N_LANES-1:0]         lane_enable;
    logic [N_LANES-1:0]         lane_update;
    logic [N_LANES-1:0]         lane_clear;
    lane_status_t [N_LANES-1:0] lane_status;

    rf_write u_rf_write (
        .i_fpga_clock  (i_fpga_clock),
        .i_rst         (i_rst),
        .i_gpio_data   (i_gpio_data),
        .o_cmd         (cmd),
        .o_cfg         (cfg),
        .o_lane_enable (lane_enable),
        .o_update      (lane_update)
    );

    // One channel per lane, configuration shared
    for (genvar l = 0; l < N_LANES; l++) begin : gen_lane
        lane_channel u_lane_channel (
            .i_fpga_clock (i_fpga_clock),
            .i_rst        (i_rst),
            .i_enable     (lane_enable[l]),
            .i_update     (lane_update[l]),
            .i_cfg        (cfg),
            .i_clear      (lane_clear[l]),
            .o_status     (lane_status[l])
        );
    end

    rf_read_mux u_rf_read_mux (
        .i_fpga_clock  (i_fpga_clock),
        .i_rst         (i_rst),
        .i_cmd         (cmd),
        .i_status      (lane_status),
        .i_lane_enable (lane_enable),
        .o_clear       (lane_clear),
        .o_gpio_data   (o_gpio_data)
    );

endmodule

/* design/rf_read_mux.sv */
module rf_read_mux (
    input  logic                                      i_fpga_clock,
    input  logic                                      i_rst,
    input  rf_pkg::rf_cmd_t                           i_cmd,
    input  rf_pkg::lane_status_t [rf_pkg::N_LANES-1:0] i_status,
    input  logic [rf_pkg::N_LANES-1:0]                i_lane_enable,
    output logic [rf_pkg::N_LANES-1:0]                o_clear,
    output logic [rf_pkg::NB_GPIO-1:0]                o_gpio_data
);

    import rf_pkg::*;

    logic               rd_space;
    logic [NB_GPIO-1:0] rd_value;
    logic [N_LANES-1:0] rd_clear;
    logic [N_LANES-1:0] busy_vec;

    // Everything from the first counter address up is read space
    assign rd_space = i_cmd.strobe && (i_cmd.addr >= ADDR_RD_BLK_ERR);

    always_comb begin
        for (int l = 0; l < N_LANES; l++) begin
            busy_vec[l] = i_status[l].busy;
        end
    end

    // Unmapped read-space addresses fall through to zero
    always_comb begin
        rd_value = '0;
        rd_clear = '0;
        for (int l = 0; l < N_LANES; l++) begin
            if (i_cmd.addr == ADDR_RD_BLK_ERR + NB_ADDR'(l)) begin
                rd_value    = NB_GPIO'(i_status[l].blk_err_cnt);
                rd_clear[l] = 1'b1;
            end
            if (i_cmd.addr == ADDR_RD_BIT_ERR + NB_ADDR'(l)) begin
                rd_value    = NB_GPIO'(i_status[l].bit_err_cnt);
                rd_clear[l] = 1'b1;
            end
        end
        // Busy bits low, enables above them
        if (i_cmd.addr == ADDR_RD_STATUS) begin
            rd_value = NB_GPIO'({i_lane_enable, busy_vec});
        end
    end

    // Read data holds until the next read, clear is a one-cycle pulse
    always_ff @(posedge i_fpga_clock) begin
        if (i_rst) begin
            o_gpio_data <= '0;
            o_clear     <= '0;
        end else begin
            o_clear <= rd_space ? rd_clear : '0;
            if (rd_space) begin
                o_gpio_data <= rd_value;
            end
        end
    end

endmodule

/* lane/lane_channel.sv */
module lane_channel (
    input  logic                 i_fpga_clock,
    input  logic                 i_rst,
    input  logic                 i_enable,
    input  logic                 i_update,
    input  rf_pkg::breaker_cfg_t i_cfg,
    input  logic                 i_clear,
    output rf_pkg::lane_status_t o_status
);

    import rf_pkg::*;

    logic [NB_BLOCK-1:0]       lfsr_q;
    logic                      lfsr_fb;
    breaker_cfg_t              cfg_q;
    breaker_state_e            state_q;
    logic [NB_PERIOD_CNT-1:0]  blk_cnt_q;
    logic [NB_REPEAT_CNT-1:0]  rpt_cnt_q;
    logic [NB_PERIOD_CNT:0]    blk_next;
    logic                      burst_end;
    logic                      period_end;
    logic                      last_period;
    logic                      corrupt;
    logic [NB_BLOCK-1:0]       tx_block;
    logic [NB_BLOCK-1:0]       diff;
    logic [NB_POP_CNT-1:0]     diff_ones;
    logic [NB_BLK_ERR_CNT-1:0] blk_err_q;
    logic [NB_BIT_ERR_CNT-1:0] bit_err_q;
    logic [NB_BLK_ERR_CNT-1:0] blk_err_base;
    logic [NB_BIT_ERR_CNT-1:0] bit_err_base;
    logic [NB_BIT_ERR_CNT:0]   bit_err_sum;

    // Payload generator, x^64 + x^63 + x^61 + x^60 + 1
    assign lfsr_fb = lfsr_q[63] ^ lfsr_q[62] ^ lfsr_q[60] ^ lfsr_q[59];

    always_ff @(posedge i_fpga_clock) begin
        if (i_rst) begin
            lfsr_q <= LFSR_SEED;
        end else if (i_enable) begin
            lfsr_q <= {lfsr_q[NB_BLOCK-2:0], lfsr_fb};
        end
    end

    // Position inside the current period, counted from the burst start
    assign blk_next    = {1'b0, blk_cnt_q} + 1'b1;
    assign burst_end   = blk_next >= {1'b0, cfg_q.burst};
    assign period_end  = blk_next >= {1'b0, cfg_q.period};
    assign last_period = (cfg_q.mode != ERR_CONT) &&
                         (({1'b0, rpt_cnt_q} + 1'b1) >= {1'b0, cfg_q.repeat_cnt});

    // Breaker FSM, one step per enabled block
    always_ff @(posedge i_fpga_clock) begin
        if (i_rst) begin
            cfg_q     <= '0;
            state_q   <= BRK_IDLE;
            blk_cnt_q <= '0;
            rpt_cnt_q <= '0;
        end else if (i_update) begin
            cfg_q     <= i_cfg;
            blk_cnt_q <= '0;
            rpt_cnt_q <= '0;
            if (i_cfg.mode == ERR_CONT || i_cfg.mode == ERR_REPEAT) begin
                state_q <= BRK_BURST;
            end else begin
                state_q <= BRK_IDLE;
            end
        end else if (i_enable && state_q != BRK_IDLE) begin
            if (period_end) begin
                blk_cnt_q <= '0;
                rpt_cnt_q <= rpt_cnt_q + 1'b1;
                state_q   <= last_period ? BRK_IDLE : BRK_BURST;
            end else begin
                blk_cnt_q <= blk_next[NB_PERIOD_CNT-1:0];
                if (state_q == BRK_BURST && burst_end) begin
                    state_q <= BRK_GAP;
                end
            end
        end
    end

    assign corrupt  = i_enable && (state_q == BRK_BURST);
    assign tx_block = lfsr_q ^ (corrupt ? cfg_q.mask : '0);

    // Checker against the clean block
    assign diff = tx_block ^ lfsr_q;

    always_comb begin
        diff_ones = '0;
        for (int i = 0; i < NB_BLOCK; i++) begin
            diff_ones = diff_ones + NB_POP_CNT'(diff[i]);
        end
    end

    // A clear lands together with the error of the same cycle
    assign blk_err_base = i_clear ? '0 : blk_err_q;
    assign bit_err_base = i_clear ? '0 : bit_err_q;
    assign bit_err_sum  = {1'b0, bit_err_base} + (NB_BIT_ERR_CNT+1)'(diff_ones);

    always_ff @(posedge i_fpga_clock) begin
        if (i_rst) begin
            blk_err_q <= '0;
            bit_err_q <= '0;
        end else if (i_enable && diff != '0) begin
            // Both counters saturate
            blk_err_q <= (&blk_err_base) ? blk_err_base : blk_err_base + 1'b1;
            bit_err_q <= bit_err_sum[NB_BIT_ERR_CNT] ? '1 : bit_err_sum[NB_BIT_ERR_CNT-1:0];
        end else if (i_clear) begin
            blk_err_q <= '0;
            bit_err_q <= '0;
        end
    end

    assign o_status.busy        = (state_q != BRK_IDLE);
    assign o_status.blk_err_cnt = blk_err_q;
    assign o_status.bit_err_cnt = bit_err_q;

endmodule

/* design/rf_write.sv */
module rf_write (
    input  logic                       i_fpga_clock,
    input  logic                       i_rst,
    input  logic [rf_pkg::NB_GPIO-1:0] i_gpio_data,
    output rf_pkg::rf_cmd_t            o_cmd,
    output rf_pkg::breaker_cfg_t       o_cfg,
    output logic [rf_pkg::N_LANES-1:0] o_lane_enable,
    output logic [rf_pkg::N_LANES-1:0] o_update
);

    import rf_pkg::*;

    logic [NB_GPIO-1:0] gpio_q;
    logic               strobe_q;
    rf_cmd_t            cmd_q;
    breaker_cfg_t       cfg_q;
    logic [N_LANES-1:0] lane_enable_q;
    logic [N_LANES-1:0] update_q;

    // Input register plus one sample of history for the strobe edge.
    // Both start high so a strobe already up at reset release is ignored
    always_ff @(posedge i_fpga_clock) begin
        if (i_rst) begin
            gpio_q   <= {1'b1, {(NB_GPIO-1){1'b0}}};
            strobe_q <= 1'b1;
        end else begin
            gpio_q   <= i_gpio_data;
            strobe_q <= gpio_q[NB_GPIO-1];
        end
    end

    // Command register, strobe is a single-cycle pulse
    always_ff @(posedge i_fpga_clock) begin
        cmd_q.addr <= gpio_q[NB_GPIO-2 -: NB_ADDR];
        cmd_q.data <= gpio_q[NB_I_DATA-1:0];
        if (i_rst) begin
            cmd_q.strobe <= 1'b0;
        end else begin
            cmd_q.strobe <= gpio_q[NB_GPIO-1] & ~strobe_q;
        end
    end

    // Write-space decode
    always_ff @(posedge i_fpga_clock) begin
        if (i_rst) begin
            cfg_q         <= '0;
            lane_enable_q <= '0;
            update_q      <= '0;
        end else begin
            update_q <= '0;
            if (cmd_q.strobe) begin
                case (cmd_q.addr)
                    ADDR_LANE_ENABLE: lane_enable_q <= cmd_q.data[N_LANES-1:0];
                    ADDR_MASK_LO: cfg_q.mask[NB_MASK_LO-1:0] <= cmd_q.data[NB_MASK_LO-1:0];
                    ADDR_MASK_MID: begin
                        cfg_q.mask[NB_MASK_LO +: NB_MASK_MID] <= cmd_q.data[NB_MASK_MID-1:0];
                    end
                    ADDR_MASK_HI: begin
                        cfg_q.mask[NB_BLOCK-1 -: NB_MASK_HI] <= cmd_q.data[NB_MASK_HI-1:0];
                    end
                    ADDR_BURST:  cfg_q.burst  <= cmd_q.data[NB_BURST_CNT-1:0];
                    ADDR_PERIOD: cfg_q.period <= cmd_q.data[NB_PERIOD_CNT-1:0];
                    ADDR_MODE: begin
                        cfg_q.repeat_cnt <= cmd_q.data[NB_REPEAT_CNT-1:0];
                        cfg_q.mode <= err_mode_e'(cmd_q.data[NB_REPEAT_CNT +: $bits(err_mode_e)]);
                    end
                    // One pulse per lane bit set in the data
                    ADDR_UPDATE: update_q <= cmd_q.data[N_LANES-1:0];
                    default: ;
                endcase
            end
        end
    end

    assign o_cmd         = cmd_q;
    assign o_cfg         = cfg_q;
    assign o_lane_enable = lane_enable_q;
    assign o_update      = update_q;

endmodule

/* common/rf_pkg.sv */
package rf_pkg;

    // GPIO word layout: strobe in bit 31, address below it, data at the bottom
    localparam int NB_GPIO        = 32;
    localparam int NB_ADDR        = 9;
    localparam int NB_I_DATA      = 22;

    localparam int N_LANES        = 4;
    localparam int NB_BLOCK       = 64;

    // Breaker and checker counters
    localparam int NB_BURST_CNT   = 10;
    localparam int NB_PERIOD_CNT  = 10;
    localparam int NB_REPEAT_CNT  = 4;
    localparam int NB_BLK_ERR_CNT = 16;
    localparam int NB_BIT_ERR_CNT = 22;
    localparam int NB_POP_CNT     = $clog2(NB_BLOCK + 1);

    // Mask arrives in three slices, low slice first
    localparam int NB_MASK_LO     = 22;
    localparam int NB_MASK_MID    = 22;
    localparam int NB_MASK_HI     = 20;

    localparam logic [NB_BLOCK-1:0] LFSR_SEED = 64'hace1_5a3c_0f96_2d71;

    // Write space
    localparam logic [NB_ADDR-1:0] ADDR_LANE_ENABLE = 9'h000;
    localparam logic [NB_ADDR-1:0] ADDR_MASK_LO     = 9'h010;
    localparam logic [NB_ADDR-1:0] ADDR_MASK_MID    = 9'h011;
    localparam logic [NB_ADDR-1:0] ADDR_MASK_HI     = 9'h012;
    localparam logic [NB_ADDR-1:0] ADDR_BURST       = 9'h020;
    localparam logic [NB_ADDR-1:0] ADDR_PERIOD      = 9'h021;
    localparam logic [NB_ADDR-1:0] ADDR_MODE        = 9'h022;
    localparam logic [NB_ADDR-1:0] ADDR_UPDATE      = 9'h030;

    // Read space, everything from the block counters up
    localparam logic [NB_ADDR-1:0] ADDR_RD_BLK_ERR  = 9'h100;
    localparam logic [NB_ADDR-1:0] ADDR_RD_BIT_ERR  = 9'h110;
    localparam logic [NB_ADDR-1:0] ADDR_RD_STATUS   = 9'h120;

    typedef enum logic [1:0] {
        ERR_OFF    = 2'd0,
        ERR_CONT   = 2'd1,
        ERR_REPEAT = 2'd2
    } err_mode_e;

    typedef enum logic [1:0] {
        BRK_IDLE,
        BRK_BURST,
        BRK_GAP
    } breaker_state_e;

    typedef struct packed {
        logic                 strobe;
        logic [NB_ADDR-1:0]   addr;
        logic [NB_I_DATA-1:0] data;
    } rf_cmd_t;

    typedef struct packed {
        err_mode_e                mode;
        logic [NB_BLOCK-1:0]      mask;
        logic [NB_BURST_CNT-1:0]  burst;
        logic [NB_PERIOD_CNT-1:0] period;
        logic [NB_REPEAT_CNT-1:0] repeat_cnt;
    } breaker_cfg_t;

    typedef struct packed {
        logic                      busy;
        logic [NB_BLK_ERR_CNT-1:0] blk_err_cnt;
        logic [NB_BIT_ERR_CNT-1:0] bit_err_cnt;
    } lane_status_t;

endpackage
